// File: bench/branch_asserts.sv
`timescale 1ns/1ps
`include "branch_defs.svh"

module branch_asserts (
	input logic clock,
	input logic rst,
	input logic flush,
	input logic issue_valid,
	input logic issue_credit,
	input logic resolve_valid,
	input logic rs_full
);
	int credits; // issue credits as the station should count them

	always_ff @(posedge clock) begin
		if (rst || flush) begin
			credits <= `BR_FU_SLOTS;
		end else begin
			credits <= credits - int'(issue_valid) + int'(issue_credit);
		end
	end

	credit_bound: assert property (@(posedge clock) disable iff (rst)
		credits <= `BR_FU_SLOTS)
		else $error("issue credits above the unit slot count");

	issue_needs_credit: assert property (@(posedge clock) disable iff (rst)
		issue_valid |-> credits > 0)
		else $error("issue with no credit left");

	quiet_after_flush: assert property (@(posedge clock) disable iff (rst)
		flush |=> !resolve_valid)
		else $error("resolution in the cycle after a flush");

	no_resolve_full_flush: assert property (@(posedge clock) disable iff (rst)
		!(resolve_valid && rs_full && flush))
		else $error("resolution while full and flushing");

endmodule

bind branch_top branch_asserts asrt0 (
	.clock(clock),
	.rst(rst),
	.flush(flush),
	.issue_valid(issue_valid),
	.issue_credit(issue_credit),
	.resolve_valid(resolve_valid),
	.rs_full(rs_full)
);

// File: bench/branch_tb.sv
`timescale 1ns/1ps
`include "branch_defs.svh"

module branch_tb;
	import branch_pkg::*;

	localparam int MAX_CYCLES = 2000; // all tests together take about 250 cycles

	logic clock;
	logic rst;
	logic flush;
	logic dispatch_valid;
	br_dispatch_t dispatch;
	logic rs_full;
	br_cdb_t cdb;
	logic resolve_credit;
	logic resolve_valid;
	br_resolve_t resolve;

	int cycle;
	int errors;
	int test_errors;
	int failed_tests;
	int checked; // resolutions compared so far
	int drive_cycle; // cycle in which the last dispatch was driven
	int returned; // downstream credits given back
	int allowed; // credit limit while back-pressure holds
	bit auto_credit;
	logic [15:0] lfsr;
	br_resolve_t got[$];
	int got_cyc[$];
	br_resolve_t exp[$];
	int exp_cyc[$]; // -1 where latency is not checked

	branch_tb_clock clk0 (.clock(clock));

	branch_top dut0 (
		.clock(clock),
		.rst(rst),
		.flush(flush),
		.dispatch_valid(dispatch_valid),
		.dispatch(dispatch),
		.rs_full(rs_full),
		.cdb(cdb),
		.resolve_credit(resolve_credit),
		.resolve_valid(resolve_valid),
		.resolve(resolve)
	);

	initial begin
		cycle = 0;
		while (cycle < MAX_CYCLES) begin
			@(posedge clock);
			cycle <= cycle + 1;
		end
		$display("run stopped after %0d cycles without finishing", cycle);
		$display("STATUS: FAIL");
		$finish;
	end

	// collect resolutions mid-cycle
	always @(negedge clock) begin
		if (!rst && resolve_valid) begin
			got.push_back(resolve);
			got_cyc.push_back(cycle);
		end
	end

	// downstream consumer returns one credit per resolution unless held
	initial begin
		resolve_credit = 1'b0;
		returned = 0;
		forever begin
			@(posedge clock);
			#2;
			if (returned < (auto_credit ? got.size() : allowed)) begin
				resolve_credit = 1'b1;
				returned++;
			end else begin
				resolve_credit = 1'b0;
			end
		end
	end

	// 16 bit fibonacci lfsr with taps 16 14 13 11
	function automatic br_word_t rand_word();
		br_word_t w;
		w = '0;
		for (int i = 0; i < `BR_XLEN; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			w = {w[`BR_XLEN-2:0], lfsr[0]};
		end
		return w;
	endfunction

	function automatic br_resolve_t model(input br_op_e op, input br_word_t pc,
			input br_word_t imm, input br_word_t a, input br_word_t b, input br_rob_t rob);
		br_resolve_t r;
		r.rob_idx = rob;
		r.link = pc + 32'd4;
		case (op)
			BR_BEQ: r.taken = (a == b);
			BR_BNE: r.taken = (a != b);
			BR_BLT: r.taken = ($signed(a) < $signed(b));
			BR_BGE: r.taken = ($signed(a) >= $signed(b));
			BR_BLTU: r.taken = (a < b);
			BR_BGEU: r.taken = (a >= b);
			default: r.taken = 1'b1; // jumps
		endcase
		r.target = (op == BR_JALR) ? ((a + imm) & ~32'd1) : (pc + imm);
		return r;
	endfunction

	function automatic br_dispatch_t make_op(input br_op_e op, input br_word_t pc,
			input br_word_t imm, input br_word_t a, input br_word_t b, input br_rob_t rob);
		br_dispatch_t d;
		d = '0;
		d.op = op;
		d.pc = pc;
		d.imm = imm;
		d.src1.ready = 1'b1;
		d.src1.value = a;
		d.src2.ready = 1'b1;
		d.src2.value = b;
		d.rob_idx = rob;
		return d;
	endfunction

	task automatic tick();
		@(posedge clock);
		#2;
	endtask

	task automatic broadcast(input br_tag_t tag, input br_word_t value);
		cdb.valid = 1'b1;
		cdb.tag = tag;
		cdb.value = value;
	endtask

	task automatic send(input br_dispatch_t d);
		while (rs_full) begin
			tick();
		end
		dispatch = d;
		dispatch_valid = 1'b1;
		drive_cycle = cycle;
		tick();
		dispatch_valid = 1'b0;
		cdb = '0; // a same-cycle broadcast lasts one cycle
	endtask

	// a and b are the operand values the unit should end up using
	task automatic expect_res(input br_dispatch_t d, input br_word_t a, input br_word_t b,
			input bit timed);
		exp.push_back(model(d.op, d.pc, d.imm, a, b, d.rob_idx));
		exp_cyc.push_back(timed ? drive_cycle + 3 : -1);
	endtask

	task automatic await_results(input string name);
		int waited;
		waited = 0;
		while (got.size() < exp.size() && waited < 60) begin
			tick();
			waited++;
		end
		if (got.size() < exp.size()) begin
			$display("%s: only %0d of %0d resolutions arrived", name, got.size(), exp.size());
			test_errors++;
		end
		while (checked < got.size() && checked < exp.size()) begin
			if (got[checked] !== exp[checked]) begin
				$display("Fail %s: expected %h actual %h", name, exp[checked], got[checked]);
				test_errors++;
			end
			if (exp_cyc[checked] >= 0 && got_cyc[checked] != exp_cyc[checked]) begin
				$display("Fail %s: latency expected cycle %0d actual %0d", name,
					exp_cyc[checked], got_cyc[checked]);
				test_errors++;
			end
			checked++;
		end
	endtask

	task automatic quiet(input string name, input int n);
		repeat (n) tick();
		if (got.size() != exp.size()) begin
			$display("%s: a resolution arrived that no dispatch asked for", name);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, test_errors);
			failed_tests++;
		end
		errors += test_errors;
		test_errors = 0;
	endtask

	task automatic reset_quiet();
		if (resolve_valid !== 1'b0) begin
			$display("Fail reset_quiet: resolve_valid expected 0 actual %b", resolve_valid);
			test_errors++;
		end
		if (rs_full !== 1'b0) begin
			$display("Fail reset_quiet: rs_full expected 0 actual %b", rs_full);
			test_errors++;
		end
		quiet("reset_quiet", 10);
		finish_test("reset_quiet");
	endtask

	task automatic cond_ops();
		br_op_e ops [6] = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
		br_dispatch_t d;
		br_word_t a;
		br_word_t b;
		for (int k = 0; k < 6; k++) begin
			for (int p = 0; p < 4; p++) begin
				a = rand_word();
				b = rand_word();
				case (p)
					1: b = a; // equal operands
					2: begin
						a = 32'h8000_0000; // most negative against most positive
						b = 32'h7fff_ffff;
					end
					3: begin
						a = 32'h0;
						b = 32'hffff_ffff;
					end
					default: ;
				endcase
				d = make_op(ops[k], rand_word(), rand_word(), a, b, 4'(k * 4 + p));
				send(d);
				expect_res(d, a, b, 1'b1);
				await_results("cond_ops");
			end
		end
		finish_test("cond_ops");
	endtask

	task automatic jump_ops();
		br_dispatch_t d;
		br_word_t a;
		br_word_t b;
		for (int k = 0; k < 6; k++) begin
			a = rand_word() | 32'd1; // odd base and even offset so jalr must clear bit 0
			b = rand_word();
			d = make_op((k % 2) ? BR_JALR : BR_JAL, rand_word(), rand_word() & ~32'd1, a, b,
				4'(k));
			send(d);
			expect_res(d, a, b, 1'b1);
			await_results("jump_ops");
		end
		finish_test("jump_ops");
	endtask

	task automatic tag_wakeup();
		br_dispatch_t da;
		br_dispatch_t db;
		br_dispatch_t dc;
		br_word_t wa;
		br_word_t wb;
		br_word_t wc;
		da = make_op(BR_BNE, rand_word(), rand_word(), rand_word(), rand_word(), 4'd1);
		da.src1.ready = 1'b0;
		da.src1.tag = 6'd5;
		db = make_op(BR_BLT, rand_word(), rand_word(), rand_word(), rand_word(), 4'd2);
		db.src1.ready = 1'b0;
		db.src1.tag = 6'd6;
		dc = make_op(BR_BGEU, rand_word(), rand_word(), rand_word(), rand_word(), 4'd3);
		dc.src2.ready = 1'b0;
		dc.src2.tag = 6'd7;
		wa = rand_word();
		wb = rand_word();
		wc = rand_word();
		send(da);
		send(db);
		broadcast(6'd7, wc); // lands in the dispatch cycle
		send(dc);
		expect_res(dc, dc.src1.value, wc, 1'b1);
		broadcast(6'd6, wb); // younger producer first
		tick();
		broadcast(6'd5, wa);
		tick();
		cdb = '0;
		expect_res(da, wa, da.src2.value, 1'b0); // older entry goes first once both are ready
		expect_res(db, wb, db.src2.value, 1'b0);
		await_results("tag_wakeup");
		finish_test("tag_wakeup");
	endtask

	task automatic back_pressure();
		br_dispatch_t d;
		br_word_t a;
		br_word_t b;
		int start;
		start = got.size();
		allowed = got.size();
		auto_credit = 1'b0;
		for (int i = 0; i < 7; i++) begin
			a = rand_word();
			b = rand_word();
			d = make_op(BR_BLTU, rand_word(), rand_word(), a, b, 4'(i));
			send(d);
			expect_res(d, a, b, 1'b0);
		end
		repeat (8) tick();
		if (got.size() - start != `BR_OUT_CREDITS) begin
			$display("Fail back_pressure: resolutions expected %0d actual %0d",
				`BR_OUT_CREDITS, got.size() - start);
			test_errors++;
		end
		if (rs_full !== 1'b1) begin
			$display("Fail back_pressure: rs_full expected 1 actual %b", rs_full);
			test_errors++;
		end
		auto_credit = 1'b1; // held credits go back now
		await_results("back_pressure");
		finish_test("back_pressure");
	endtask

	task automatic flush_drain();
		br_dispatch_t d;
		br_word_t a;
		d = make_op(BR_BEQ, rand_word(), rand_word(), rand_word(), rand_word(), 4'd1);
		d.src1.ready = 1'b0;
		d.src1.tag = 6'd9;
		send(d);
		d.rob_idx = 4'd2;
		d.src1.tag = 6'd10;
		send(d);
		send(make_op(BR_BNE, rand_word(), rand_word(), rand_word(), rand_word(), 4'd3));
		tick(); // the ready op moves into the unit
		flush = 1'b1;
		tick();
		flush = 1'b0;
		broadcast(6'd9, rand_word()); // tags of flushed entries wake nothing
		tick();
		broadcast(6'd10, rand_word());
		tick();
		cdb = '0;
		quiet("flush_drain", 8);
		if (rs_full !== 1'b0) begin
			$display("Fail flush_drain: rs_full expected 0 actual %b", rs_full);
			test_errors++;
		end
		a = rand_word();
		d = make_op(BR_BGE, rand_word(), rand_word(), a, a, 4'd4);
		send(d);
		expect_res(d, a, a, 1'b1);
		await_results("flush_drain");
		finish_test("flush_drain");
	endtask

	initial begin
		lfsr = 16'd73;
		rst = 1'b1;
		flush = 1'b0;
		dispatch_valid = 1'b0;
		dispatch = '0;
		cdb = '0;
		auto_credit = 1'b1;
		allowed = 0;
		errors = 0;
		test_errors = 0;
		failed_tests = 0;
		checked = 0;
		drive_cycle = 0;
		repeat (3) @(posedge clock);
		#2;
		rst = 1'b0;
		reset_quiet();
		cond_ops();
		jump_ops();
		tag_wakeup();
		back_pressure();
		flush_drain();
		$display("tests 6, failed %0d, errors %0d", failed_tests, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: bench/branch_tb_clock.sv
`timescale 1ns/1ps

module branch_tb_clock (
	output logic clock
);
	localparam real HALF_PERIOD = 20.0; // 40 ns period

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

endmodule

// File: hdl/branch_cond.sv
`timescale 1ns/1ps
`include "branch_defs.svh"

module branch_cond (
	input logic clock,
	input logic rst,
	input logic clear,
	input logic load,
	input branch_pkg::br_op_e op,
	input logic [`BR_XLEN-1:0] rs1,
	input logic [`BR_XLEN-1:0] rs2,
	output logic cond_valid,
	output logic cond
);
	import branch_pkg::*;

	logic result;
	logic signed_lt;
	logic unsigned_lt;

	assign signed_lt = $signed(rs1) < $signed(rs2);
	assign unsigned_lt = rs1 < rs2;

	always_comb begin
		case (op)
			BR_BEQ: result = rs1 == rs2;
			BR_BNE: result = rs1 != rs2;
			BR_BLT: result = signed_lt;
			BR_BGE: result = !signed_lt;
			BR_BLTU: result = unsigned_lt;
			BR_BGEU: result = !unsigned_lt;
			default: result = 1'b1; // jal, jalr
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst || clear) begin
			cond_valid <= 1'b0;
		end else if (load) begin
			cond_valid <= 1'b1; // held until the slot frees
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			cond <= result;
		end
	end

endmodule

// File: hdl/branch_defs.svh
`ifndef BRANCH_DEFS_SVH
`define BRANCH_DEFS_SVH

// datapath
`define BR_XLEN 32 // one word for data and addresses
`define BR_TAG_BITS 6 // physical register tag
`define BR_ROB_BITS 4 // reorder buffer index used for ordering

// reservation station
`define BR_RS_DEPTH 4
`define BR_RS_IDX_BITS 2 // index and age rank of an entry
`define BR_RS_CNT_BITS 3 // occupancy from 0 to BR_RS_DEPTH

// station to unit credits with one per unit slot
`define BR_FU_SLOTS 1
`define BR_FU_CNT_BITS 1

// unit to reorder buffer credits
`define BR_OUT_CREDITS 2
`define BR_OUT_CNT_BITS 2

// link is the address of the next sequential instruction
`define BR_LINK_OFFSET 4

`endif

// File: hdl/branch_pkg.sv
`include "branch_defs.svh"

package branch_pkg;

	typedef logic [`BR_XLEN-1:0] br_word_t;
	typedef logic [`BR_TAG_BITS-1:0] br_tag_t;
	typedef logic [`BR_ROB_BITS-1:0] br_rob_t;

	// funct3 encoding for the conditional ops and the two free codes for jumps
	typedef enum logic [2:0] {
		BR_BEQ = 3'b000,
		BR_BNE = 3'b001,
		BR_JAL = 3'b010,
		BR_JALR = 3'b011,
		BR_BLT = 3'b100,
		BR_BGE = 3'b101,
		BR_BLTU = 3'b110,
		BR_BGEU = 3'b111
	} br_op_e;

	typedef struct packed {
		logic ready; // value holds the operand
		br_tag_t tag; // producer tag while not ready
		br_word_t value;
	} br_src_t;

	typedef struct packed {
		br_op_e op;
		br_word_t pc;
		br_word_t imm; // already sign extended
		br_src_t src1;
		br_src_t src2;
		br_rob_t rob_idx;
	} br_dispatch_t;

	typedef struct packed {
		br_op_e op;
		br_word_t pc;
		br_word_t imm;
		br_word_t rs1_value;
		br_word_t rs2_value;
		br_rob_t rob_idx;
	} br_issue_t;

	// one result bus broadcast per cycle
	typedef struct packed {
		logic valid;
		br_tag_t tag;
		br_word_t value;
	} br_cdb_t;

	typedef struct packed {
		br_rob_t rob_idx;
		logic taken;
		br_word_t target;
		br_word_t link;
	} br_resolve_t;

endpackage

// File: hdl/branch_rs.sv
`timescale 1ns/1ps
`include "branch_defs.svh"

module branch_rs (
	input logic clock,
	input logic rst,
	input logic flush,
	input logic dispatch_valid,
	input branch_pkg::br_dispatch_t dispatch,
	input branch_pkg::br_cdb_t cdb,
	input logic issue_credit,
	output logic rs_full,
	output logic issue_valid,
	output branch_pkg::br_issue_t issue
);
	import branch_pkg::*;

	typedef struct packed {
		logic [`BR_RS_IDX_BITS-1:0] age; // 0 is the oldest live entry
		br_dispatch_t op;
	} rs_entry_t;

	logic [`BR_RS_DEPTH-1:0] valid;
	rs_entry_t entry [`BR_RS_DEPTH];
	logic [`BR_RS_DEPTH-1:0] ready;
	logic [`BR_RS_CNT_BITS-1:0] alloc_count; // live entries and the next age rank
	logic [`BR_RS_CNT_BITS-1:0] count_after_issue;
	logic [`BR_FU_CNT_BITS-1:0] fu_credits;
	logic [`BR_RS_IDX_BITS-1:0] sel_idx;
	logic [`BR_RS_IDX_BITS-1:0] free_idx;
	logic sel_found;
	logic dispatch_fire;
	br_dispatch_t incoming;
	rs_entry_t sel_entry;

	// capture a broadcast for a source still waiting on its tag
	function automatic br_src_t wake(input br_src_t src, input br_cdb_t bus);
		br_src_t woke;
		woke = src;
		if (!src.ready && bus.valid && bus.tag == src.tag) begin
			woke.ready = 1'b1;
			woke.value = bus.value;
		end
		return woke;
	endfunction

	always_comb begin
		for (int i = 0; i < `BR_RS_DEPTH; i++) begin
			ready[i] = valid[i] && entry[i].op.src1.ready && entry[i].op.src2.ready;
		end
	end

	// oldest ready entry has the smallest age rank
	always_comb begin
		sel_found = 1'b0;
		sel_idx = '0;
		for (int i = 0; i < `BR_RS_DEPTH; i++) begin
			if (ready[i] && (!sel_found || entry[i].age < entry[sel_idx].age)) begin
				sel_found = 1'b1;
				sel_idx = `BR_RS_IDX_BITS'(i);
			end
		end
	end

	always_comb begin
		free_idx = '0;
		for (int i = `BR_RS_DEPTH - 1; i >= 0; i--) begin
			if (!valid[i]) begin
				free_idx = `BR_RS_IDX_BITS'(i); // lowest free slot wins
			end
		end
	end

	assign rs_full = &valid;
	assign dispatch_fire = dispatch_valid && !rs_full;
	assign issue_valid = sel_found && (fu_credits != '0) && !flush;
	assign count_after_issue = alloc_count - `BR_RS_CNT_BITS'(issue_valid);
	assign sel_entry = entry[sel_idx];

	always_comb begin
		incoming = dispatch;
		incoming.src1 = wake(dispatch.src1, cdb); // same-cycle broadcast
		incoming.src2 = wake(dispatch.src2, cdb);
	end

	assign issue.op = sel_entry.op.op;
	assign issue.pc = sel_entry.op.pc;
	assign issue.imm = sel_entry.op.imm;
	assign issue.rs1_value = sel_entry.op.src1.value;
	assign issue.rs2_value = sel_entry.op.src2.value;
	assign issue.rob_idx = sel_entry.op.rob_idx;

	always_ff @(posedge clock) begin
		if (rst || flush) begin
			valid <= '0;
			alloc_count <= '0;
		end else begin
			if (issue_valid) begin
				valid[sel_idx] <= 1'b0;
			end
			if (dispatch_fire) begin
				valid[free_idx] <= 1'b1;
			end
			alloc_count <= count_after_issue + `BR_RS_CNT_BITS'(dispatch_fire);
		end
	end

	// wakeup and age compaction on live entries
	always_ff @(posedge clock) begin
		for (int i = 0; i < `BR_RS_DEPTH; i++) begin
			if (valid[i]) begin
				entry[i].op.src1 <= wake(entry[i].op.src1, cdb);
				entry[i].op.src2 <= wake(entry[i].op.src2, cdb);
				if (issue_valid && entry[i].age > sel_entry.age) begin
					entry[i].age <= entry[i].age - `BR_RS_IDX_BITS'(1);
				end
			end
		end
		if (dispatch_fire) begin
			entry[free_idx].op <= incoming;
			entry[free_idx].age <= count_after_issue[`BR_RS_IDX_BITS-1:0]; // youngest
		end
	end

	always_ff @(posedge clock) begin
		if (rst || flush) begin
			fu_credits <= `BR_FU_CNT_BITS'(`BR_FU_SLOTS);
		end else if (issue_valid && !issue_credit) begin
			fu_credits <= fu_credits - `BR_FU_CNT_BITS'(1);
		end else if (!issue_valid && issue_credit) begin
			fu_credits <= fu_credits + `BR_FU_CNT_BITS'(1);
		end
	end

endmodule

// File: hdl/branch_top.sv
`timescale 1ns/1ps

module branch_top (
	input logic clock,
	input logic rst,
	input logic flush,
	input logic dispatch_valid,
	input branch_pkg::br_dispatch_t dispatch,
	output logic rs_full,
	input branch_pkg::br_cdb_t cdb,
	input logic resolve_credit,
	output logic resolve_valid,
	output branch_pkg::br_resolve_t resolve
);
	import branch_pkg::*;

	logic issue_valid;
	br_issue_t issue;
	logic issue_credit; // unit slot freed

	branch_rs rs0 (
		.clock(clock),
		.rst(rst),
		.flush(flush),
		.dispatch_valid(dispatch_valid),
		.dispatch(dispatch),
		.cdb(cdb),
		.issue_credit(issue_credit),
		.rs_full(rs_full),
		.issue_valid(issue_valid),
		.issue(issue)
	);

	branch_unit unit0 (
		.clock(clock),
		.rst(rst),
		.flush(flush),
		.issue_valid(issue_valid),
		.issue(issue),
		.resolve_credit(resolve_credit),
		.issue_credit(issue_credit),
		.resolve_valid(resolve_valid),
		.resolve(resolve)
	);

endmodule

// File: hdl/branch_unit.sv
`timescale 1ns/1ps
`include "branch_defs.svh"

module branch_unit (
	input logic clock,
	input logic rst,
	input logic flush,
	input logic issue_valid,
	input branch_pkg::br_issue_t issue,
	input logic resolve_credit,
	output logic issue_credit,
	output logic resolve_valid,
	output branch_pkg::br_resolve_t resolve
);
	import branch_pkg::*;

	br_issue_t work; // operation held in the slot
	logic busy;
	logic cond_valid;
	logic cond;
	logic is_jump;
	logic [`BR_OUT_CNT_BITS-1:0] out_credits;
	br_word_t opa_mux_out;
	br_word_t target_sum;

	assign is_jump = (work.op == BR_JAL) || (work.op == BR_JALR);

	// jalr is register relative, everything else pc relative
	assign opa_mux_out = (work.op == BR_JALR) ? work.rs1_value : work.pc;
	assign target_sum = opa_mux_out + work.imm;

	branch_cond cond0 (
		.clock(clock),
		.rst(rst),
		.clear(flush || resolve_valid),
		.load(busy && !cond_valid),
		.op(work.op),
		.rs1(work.rs1_value),
		.rs2(work.rs2_value),
		.cond_valid(cond_valid),
		.cond(cond)
	);

	assign resolve_valid = busy && cond_valid && (out_credits != '0) && !flush;
	assign issue_credit = resolve_valid; // slot frees as the result leaves

	assign resolve.rob_idx = work.rob_idx;
	assign resolve.taken = is_jump || cond;
	assign resolve.target = (work.op == BR_JALR) ? {target_sum[`BR_XLEN-1:1], 1'b0}
		: target_sum;
	assign resolve.link = work.pc + `BR_XLEN'(`BR_LINK_OFFSET);

	always_ff @(posedge clock) begin
		if (rst || flush) begin
			busy <= 1'b0;
		end else if (resolve_valid) begin
			busy <= 1'b0;
		end else if (issue_valid) begin
			busy <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (issue_valid && !busy) begin
			work <= issue;
		end
	end

	// downstream credits survive a flush
	always_ff @(posedge clock) begin
		if (rst) begin
			out_credits <= `BR_OUT_CNT_BITS'(`BR_OUT_CREDITS);
		end else if (resolve_valid && !resolve_credit) begin
			out_credits <= out_credits - `BR_OUT_CNT_BITS'(1);
		end else if (!resolve_valid && resolve_credit) begin
			out_credits <= out_credits + `BR_OUT_CNT_BITS'(1);
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the branch resolution testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module branch_tb -o branch_sim

./obj_dir/branch_sim 2>&1 | tee sim.log

# the run counts as passed only when the pass line is in the log
grep -qx "STATUS: PASS" sim.log
echo "simulation passed"

// File: src.f
+incdir+hdl
hdl/branch_pkg.sv
hdl/branch_cond.sv
hdl/branch_rs.sv
hdl/branch_unit.sv
hdl/branch_top.sv
bench/branch_tb_clock.sv
bench/branch_asserts.sv
bench/branch_tb.sv
